// File: run.sh
#!/usr/bin/env bash
# build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/100ps -f vlog.f --top-module exec_unit_tb \
    -o exec_unit_sim \
    && ./obj_dir/exec_unit_sim > sim.log 2>&1 \
    && ! grep -q "Something failed" sim.log \
    && { echo "simulation passed, see sim.log"; exit 0; } \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: rv32i_config.svh
/*
    RV32I execute slice configuration
    data word width and register index width shared by the
    package types
*/

`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// integer data and address width
`define RV_XLEN 32

// x0..x31
`define RV_REG_AW 5

`endif

// File: source/alu.sv
/*
    RV32I ALU
    picks both operands from the execute packet and computes the
    arithmetic, logic, shift or address result
*/

module alu (
    input  rv32i_pkg::ex_pkt_t i_pkt,
    output rv32i_pkg::word_t   o_result
);

    rv32i_pkg::word_t op1;
    rv32i_pkg::word_t op2;
    logic [4:0]       shamt;

    assign op1   = (i_pkt.ctrl.alumux1_sel == rv32i_pkg::alumux1_pc) ? i_pkt.pc
                                                                     : i_pkt.rs1_data;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_pkt.ctrl.alumux2_sel)
            rv32i_pkg::alumux2_u_imm: op2 = i_pkt.imm_u;
            rv32i_pkg::alumux2_s_imm: op2 = i_pkt.imm_s;
            rv32i_pkg::alumux2_j_imm: op2 = i_pkt.imm_j;
            rv32i_pkg::alumux2_rs2:   op2 = i_pkt.rs2_data;
            default:                  op2 = i_pkt.imm_i;
        endcase
    end

    always_comb begin
        case (i_pkt.ctrl.aluop)
            rv32i_pkg::alu_sub:  o_result = op1 - op2;
            rv32i_pkg::alu_sll:  o_result = op1 << shamt;
            rv32i_pkg::alu_slt:  o_result = rv32i_pkg::word_t'($signed(op1) < $signed(op2));
            rv32i_pkg::alu_sltu: o_result = rv32i_pkg::word_t'(op1 < op2);
            rv32i_pkg::alu_xor:  o_result = op1 ^ op2;
            rv32i_pkg::alu_srl:  o_result = op1 >> shamt;
            rv32i_pkg::alu_sra:  o_result = rv32i_pkg::word_t'($signed(op1) >>> shamt);
            rv32i_pkg::alu_or:   o_result = op1 | op2;
            rv32i_pkg::alu_and:  o_result = op1 & op2;
            default:             o_result = op1 + op2;
        endcase
    end

endmodule

// File: source/branch_cmp.sv
/*
    RV32I branch comparator
    compares rs1 against rs2 or the I immediate, for branch
    decisions and set-less-than results
*/

module branch_cmp (
    input  rv32i_pkg::ex_pkt_t i_pkt,
    output logic               o_br_en
);

    rv32i_pkg::word_t a;
    rv32i_pkg::word_t b;

    assign a = i_pkt.rs1_data;
    assign b = (i_pkt.ctrl.cmpmux_sel == rv32i_pkg::cmpmux_i_imm) ? i_pkt.imm_i
                                                                  : i_pkt.rs2_data;

    always_comb begin
        case (i_pkt.ctrl.cmpop)
            rv32i_pkg::cmp_bne:  o_br_en = (a != b);
            rv32i_pkg::cmp_blt:  o_br_en = ($signed(a) < $signed(b));
            rv32i_pkg::cmp_bge:  o_br_en = ($signed(a) >= $signed(b));
            rv32i_pkg::cmp_bltu: o_br_en = (a < b);
            rv32i_pkg::cmp_bgeu: o_br_en = (a >= b);
            default:             o_br_en = (a == b);
        endcase
    end

endmodule

// File: source/control_rom.sv
/*
    RV32I control ROM
    decodes opcode, funct3 and funct7 into the ALU, comparator,
    memory strobe and writeback selections of one instruction
*/

module control_rom (
    input  rv32i_pkg::opcode_e i_opcode,
    input  logic [2:0]         i_funct3,
    input  logic [6:0]         i_funct7,
    output rv32i_pkg::ctrl_t   o_ctrl
);

    logic is_reg;

    // register form picks rs2 and allows sub
    assign is_reg = (i_opcode == rv32i_pkg::op_reg);

    always_comb begin
        o_ctrl                = '0;
        o_ctrl.aluop          = rv32i_pkg::alu_add;
        o_ctrl.alumux1_sel    = rv32i_pkg::alumux1_rs1;
        o_ctrl.alumux2_sel    = rv32i_pkg::alumux2_i_imm;
        o_ctrl.cmpop          = rv32i_pkg::cmp_beq;
        o_ctrl.cmpmux_sel     = rv32i_pkg::cmpmux_rs2;
        o_ctrl.wbmux_sel      = rv32i_pkg::wb_alu_out;

        case (i_opcode)
            rv32i_pkg::op_lui: begin
                o_ctrl.wb           = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.wbmux_sel    = rv32i_pkg::wb_u_imm;
            end
            rv32i_pkg::op_auipc: begin
                o_ctrl.ex           = 1'b1;
                o_ctrl.alumux1_sel  = rv32i_pkg::alumux1_pc;
                o_ctrl.alumux2_sel  = rv32i_pkg::alumux2_u_imm;
                o_ctrl.wb           = 1'b1;
                o_ctrl.load_regfile = 1'b1;
            end
            rv32i_pkg::op_jal: begin
                o_ctrl.ex           = 1'b1;
                o_ctrl.alumux1_sel  = rv32i_pkg::alumux1_pc;
                o_ctrl.alumux2_sel  = rv32i_pkg::alumux2_j_imm;
                o_ctrl.is_jump      = 1'b1;
                o_ctrl.wb           = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.wbmux_sel    = rv32i_pkg::wb_pc_plus4;
            end
            rv32i_pkg::op_jalr: begin
                o_ctrl.ex           = 1'b1;
                o_ctrl.is_jump      = 1'b1;
                o_ctrl.wb           = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.wbmux_sel    = rv32i_pkg::wb_pc_plus4;
            end
            rv32i_pkg::op_br: begin
                o_ctrl.ex        = 1'b1;
                o_ctrl.cmpop     = rv32i_pkg::cmp_op_e'(i_funct3);
                o_ctrl.is_branch = 1'b1;
            end
            rv32i_pkg::op_load: begin
                // register write happens in the memory stage
                o_ctrl.ex            = 1'b1;
                o_ctrl.mem           = 1'b1;
                o_ctrl.data_mem_read = 1'b1;
                o_ctrl.wb            = 1'b1;
            end
            rv32i_pkg::op_store: begin
                o_ctrl.ex             = 1'b1;
                o_ctrl.alumux2_sel    = rv32i_pkg::alumux2_s_imm;
                o_ctrl.mem            = 1'b1;
                o_ctrl.data_mem_write = 1'b1;
            end
            rv32i_pkg::op_imm, rv32i_pkg::op_reg: begin
                o_ctrl.ex           = 1'b1;
                o_ctrl.wb           = 1'b1;
                o_ctrl.load_regfile = 1'b1;
                if (is_reg) begin
                    o_ctrl.alumux2_sel = rv32i_pkg::alumux2_rs2;
                end else begin
                    o_ctrl.cmpmux_sel  = rv32i_pkg::cmpmux_i_imm;
                end
                case (i_funct3)
                    3'b000: o_ctrl.aluop = (is_reg && i_funct7[5]) ? rv32i_pkg::alu_sub
                                                                   : rv32i_pkg::alu_add;
                    3'b001: o_ctrl.aluop = rv32i_pkg::alu_sll;
                    3'b010: begin
                        o_ctrl.cmpop     = rv32i_pkg::cmp_blt;
                        o_ctrl.wbmux_sel = rv32i_pkg::wb_br_en;
                    end
                    3'b011: begin
                        o_ctrl.cmpop     = rv32i_pkg::cmp_bltu;
                        o_ctrl.wbmux_sel = rv32i_pkg::wb_br_en;
                    end
                    3'b100: o_ctrl.aluop = rv32i_pkg::alu_xor;
                    3'b101: o_ctrl.aluop = i_funct7[5] ? rv32i_pkg::alu_sra
                                                       : rv32i_pkg::alu_srl;
                    3'b110: o_ctrl.aluop = rv32i_pkg::alu_or;
                    default: o_ctrl.aluop = rv32i_pkg::alu_and;
                endcase
            end
            default: ;
        endcase
    end

    // one memory access per instruction
    always_comb begin
        assert (!(o_ctrl.data_mem_read && o_ctrl.data_mem_write))
            else $error("control_rom: read and write strobes both set");
    end

endmodule

// File: source/decode_stage.sv
/*
    RV32I decode stage
    runs the control ROM, forms the sign-extended immediates and
    registers the execute packet for the next cycle
*/

module decode_stage (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_valid,
    input  rv32i_pkg::word_t    i_instr,
    input  rv32i_pkg::word_t    i_pc,
    input  rv32i_pkg::word_t    i_rs1_data,
    input  rv32i_pkg::word_t    i_rs2_data,
    output rv32i_pkg::ex_pkt_t  o_pkt
);

    rv32i_pkg::opcode_e opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    rv32i_pkg::ctrl_t   ctrl;
    rv32i_pkg::ex_pkt_t pkt_d;

    assign opcode = rv32i_pkg::opcode_e'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    control_rom u_control_rom (
        .i_opcode (opcode),
        .i_funct3 (funct3),
        .i_funct7 (funct7),
        .o_ctrl   (ctrl)
    );

    always_comb begin
        pkt_d.valid    = i_valid;
        pkt_d.ctrl     = ctrl;
        pkt_d.pc       = i_pc;
        pkt_d.rs1_data = i_rs1_data;
        pkt_d.rs2_data = i_rs2_data;
        pkt_d.rd       = i_instr[11:7];
        pkt_d.imm_i    = {{21{i_instr[31]}}, i_instr[30:20]};
        pkt_d.imm_s    = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
        pkt_d.imm_b    = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                          i_instr[11:8], 1'b0};
        pkt_d.imm_u    = {i_instr[31:12], 12'h000};
        pkt_d.imm_j    = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                          i_instr[30:21], 1'b0};
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pkt.valid <= 1'b0;
        end else begin
            o_pkt <= pkt_d;
        end
    end

endmodule

// File: source/exec_unit.sv
/*
    RV32I execute slice top level
    decode register, ALU and branch comparator in parallel, then
    the registered writeback select, two cycles in to out
*/

module exec_unit (
    input  logic               i_clk,
    input  logic               i_reset,
    input  logic               i_valid,
    input  rv32i_pkg::word_t   i_instr,
    input  rv32i_pkg::word_t   i_pc,
    input  rv32i_pkg::word_t   i_rs1_data,
    input  rv32i_pkg::word_t   i_rs2_data,
    output rv32i_pkg::ex_res_t o_res
);

    rv32i_pkg::ex_pkt_t pkt;
    rv32i_pkg::word_t   alu_result;
    logic               br_en;

    decode_stage u_decode_stage (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_pkt      (pkt)
    );

    alu u_alu (
        .i_pkt    (pkt),
        .o_result (alu_result)
    );

    branch_cmp u_branch_cmp (
        .i_pkt   (pkt),
        .o_br_en (br_en)
    );

    writeback_select u_writeback_select (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_pkt        (pkt),
        .i_alu_result (alu_result),
        .i_br_en      (br_en),
        .o_res        (o_res)
    );

endmodule

// File: source/rv32i_pkg.sv
/*
    RV32I execute slice types
    opcode, ALU, comparator and mux select encodings, the control
    packet from the control ROM, the registered execute packet and
    the final execute result
*/

`include "rv32i_config.svh"

package rv32i_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // encoded as branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {alumux1_rs1, alumux1_pc} alumux1_e;

    typedef enum logic [2:0] {
        alumux2_i_imm, alumux2_u_imm, alumux2_s_imm, alumux2_j_imm, alumux2_rs2
    } alumux2_e;

    typedef enum logic {cmpmux_rs2, cmpmux_i_imm} cmpmux_e;

    typedef enum logic [1:0] {wb_alu_out, wb_br_en, wb_u_imm, wb_pc_plus4} wbmux_e;

    typedef struct packed {
        logic     ex;
        logic     mem;
        logic     wb;
        alu_op_e  aluop;
        alumux1_e alumux1_sel;
        alumux2_e alumux2_sel;
        cmp_op_e  cmpop;
        cmpmux_e  cmpmux_sel;
        logic     is_branch;
        logic     is_jump;
        logic     data_mem_read;
        logic     data_mem_write;
        logic     load_regfile;
        wbmux_e   wbmux_sel;
    } ctrl_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_u;
        word_t     imm_j;
        reg_addr_t rd;
    } ex_pkt_t;

    typedef struct packed {
        logic      valid;
        logic      rd_we;
        reg_addr_t rd;
        word_t     rd_data;
        logic      br_taken;
        word_t     target;
        logic      mem_read;
        logic      mem_write;
        word_t     mem_addr;
        word_t     store_data;
    } ex_res_t;

endpackage

// File: source/writeback_select.sv
/*
    RV32I writeback select
    merges the ALU and comparator outputs into the register write,
    branch target and memory request, and registers the result
*/

module writeback_select (
    input  logic               i_clk,
    input  logic               i_reset,
    input  rv32i_pkg::ex_pkt_t i_pkt,
    input  rv32i_pkg::word_t   i_alu_result,
    input  logic               i_br_en,
    output rv32i_pkg::ex_res_t o_res
);

    rv32i_pkg::ex_res_t res_d;
    rv32i_pkg::word_t   pc_plus4;

    assign pc_plus4 = i_pkt.pc + rv32i_pkg::word_t'(4);

    always_comb begin
        res_d.valid      = i_pkt.valid;
        res_d.rd         = i_pkt.rd;
        // x0 is never written
        res_d.rd_we      = i_pkt.valid && i_pkt.ctrl.load_regfile && (i_pkt.rd != '0);
        res_d.br_taken   = i_pkt.valid &&
                           (i_pkt.ctrl.is_jump || (i_pkt.ctrl.is_branch && i_br_en));
        res_d.mem_read   = i_pkt.valid && i_pkt.ctrl.data_mem_read;
        res_d.mem_write  = i_pkt.valid && i_pkt.ctrl.data_mem_write;
        res_d.mem_addr   = i_alu_result;
        res_d.store_data = i_pkt.rs2_data;

        case (i_pkt.ctrl.wbmux_sel)
            rv32i_pkg::wb_br_en:    res_d.rd_data = rv32i_pkg::word_t'(i_br_en);
            rv32i_pkg::wb_u_imm:    res_d.rd_data = i_pkt.imm_u;
            rv32i_pkg::wb_pc_plus4: res_d.rd_data = pc_plus4;
            default:                res_d.rd_data = i_alu_result;
        endcase

        if (i_pkt.ctrl.is_branch) begin
            res_d.target = i_pkt.pc + i_pkt.imm_b;
        end else if (i_pkt.ctrl.is_jump) begin
            // jalr is the jump that adds to rs1
            res_d.target = (i_pkt.ctrl.alumux1_sel == rv32i_pkg::alumux1_rs1) ?
                           {i_alu_result[31:1], 1'b0} : i_alu_result;
        end else begin
            res_d.target = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_res.valid     <= 1'b0;
            o_res.rd_we     <= 1'b0;
            o_res.br_taken  <= 1'b0;
            o_res.mem_read  <= 1'b0;
            o_res.mem_write <= 1'b0;
        end else begin
            o_res <= res_d;
        end
    end

    // idle result slots carry no side effects
    assert property (@(posedge i_clk) disable iff (i_reset)
        !o_res.valid |-> !(o_res.rd_we || o_res.mem_read || o_res.mem_write))
        else $error("writeback_select: strobe set on an idle result");

endmodule

// File: test/clock_gen.sv
/*
    testbench clock source
    free-running clock with a 4 ns period
*/

module clock_gen (
    output logic o_clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial o_clk = 1'b0;

    // half period
    always #2 o_clk = ~o_clk;

endmodule

// File: test/exec_testdata.txt
# instr pc rs1 rs2 | exp rd_we rd rd_data | br_taken target | mem_read mem_write mem_addr
# all hex; rd_data, target and mem_addr only matter when their enable is 1
002081b3 00000000 00000005 00000007 1 03 0000000c 0 00000000 0 0 00000000
40208233 00000004 00000005 00000007 1 04 fffffffe 0 00000000 0 0 00000000
0020c2b3 00000008 f0f0f0f0 0ff00ff0 1 05 ff00ff00 0 00000000 0 0 00000000
0020e333 0000000c f0f00000 0000f0f0 1 06 f0f0f0f0 0 00000000 0 0 00000000
0020f3b3 00000010 f0f0f0f0 ff00ff00 1 07 f000f000 0 00000000 0 0 00000000
00209433 00000014 00000003 00000024 1 08 00000030 0 00000000 0 0 00000000
0020d4b3 00000018 80000000 00000004 1 09 08000000 0 00000000 0 0 00000000
4020d533 0000001c 80000000 00000004 1 0a f8000000 0 00000000 0 0 00000000
0020a5b3 00000020 ffffffff 00000001 1 0b 00000001 0 00000000 0 0 00000000
0020b633 00000024 ffffffff 00000001 1 0c 00000000 0 00000000 0 0 00000000
ff008693 00000028 00000100 00000000 1 0d 000000f0 0 00000000 0 0 00000000
fff0a713 0000002c 00000005 00000000 1 0e 00000000 0 00000000 0 0 00000000
fff0b793 00000030 00000005 00000000 1 0f 00000001 0 00000000 0 0 00000000
4080d813 00000034 80001234 00000000 1 10 ff800012 0 00000000 0 0 00000000
0ff0c893 00000038 12345678 00000000 1 11 12345687 0 00000000 0 0 00000000
12345937 0000003c 00000000 00000000 1 12 12345000 0 00000000 0 0 00000000
00001997 00000100 00000000 00000000 1 13 00001100 0 00000000 0 0 00000000
010000ef 00000200 00000000 00000000 1 01 00000204 1 00000210 0 0 00000000
003082e7 00000300 00001000 00000000 1 05 00000304 1 00001002 0 0 00000000
ff9ff06f 00000400 00000000 00000000 0 00 00000000 1 000003f8 0 0 00000000
00208463 00000500 00000007 00000007 0 00 00000000 1 00000508 0 0 00000000
00209463 00000500 00000007 00000007 0 00 00000000 0 00000000 0 0 00000000
0020c463 00000500 ffffffff 00000001 0 00 00000000 1 00000508 0 0 00000000
0020d463 00000500 ffffffff 00000001 0 00 00000000 0 00000000 0 0 00000000
0020e463 00000500 ffffffff 00000001 0 00 00000000 0 00000000 0 0 00000000
0020f463 00000500 ffffffff 00000001 0 00 00000000 1 00000508 0 0 00000000
0100a303 00000600 00001000 00000000 0 00 00000000 0 00000000 1 0 00001010
fe20ae23 00000604 00002000 5a5a1234 0 00 00000000 0 00000000 0 1 00001ffc
00108013 00000608 00000005 00000000 0 00 00000000 0 00000000 0 0 00000000

// File: test/exec_unit_tb.sv
/*
    exec_unit testbench
    reads instruction vectors with hand-derived expected results,
    drives them back to back with random idle gaps, checks every
    result, its latency and the idle slots, under a watchdog
*/

module exec_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        rv32i_pkg::word_t     instr;
        rv32i_pkg::word_t     pc;
        rv32i_pkg::word_t     rs1;
        rv32i_pkg::word_t     rs2;
        logic                 rd_we;
        rv32i_pkg::reg_addr_t rd;
        rv32i_pkg::word_t     rd_data;
        logic                 br_taken;
        rv32i_pkg::word_t     target;
        logic                 mem_read;
        logic                 mem_write;
        rv32i_pkg::word_t     mem_addr;
    } vector_t;

    logic               clk;
    logic               i_reset;
    logic               i_valid;
    rv32i_pkg::word_t   i_instr;
    rv32i_pkg::word_t   i_pc;
    rv32i_pkg::word_t   i_rs1_data;
    rv32i_pkg::word_t   i_rs2_data;
    rv32i_pkg::ex_res_t o_res;

    vector_t vecs [0:63];
    int      sent_cycle [0:63];
    int      exp_q [$];
    int      n_vec = 0;
    int      n_done = 0;
    int      n_err = 0;
    int      n_pass = 0;
    int      cycle = 0;
    bit      loaded = 1'b0;

    clock_gen u_clock_gen (
        .o_clk (clk)
    );

    exec_unit u_exec_unit (
        .i_clk      (clk),
        .i_reset    (i_reset),
        .i_valid    (i_valid),
        .i_instr    (i_instr),
        .i_pc       (i_pc),
        .i_rs1_data (i_rs1_data),
        .i_rs2_data (i_rs2_data),
        .o_res      (o_res)
    );

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_word(input string name, input rv32i_pkg::word_t got,
                              input rv32i_pkg::word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t %s: got %h, expected %h", $realtime, name, got, exp);
            n_err++;
        end
    endtask

    task automatic check_addr(input string name, input rv32i_pkg::reg_addr_t got,
                              input rv32i_pkg::reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %t %s: got %0d, expected %0d", $realtime, name, got, exp);
            n_err++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %t %s: got %b, expected %b", $realtime, name, got, exp);
            n_err++;
        end
    endtask

    task automatic load_vectors(output bit ok);
        int               fd;
        int               cnt;
        int               n;
        string            line;
        rv32i_pkg::word_t c [0:11];
        ok = 1'b0;
        n = 0;
        fd = $fopen("test/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/exec_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") continue;
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                              c[0], c[1], c[2], c[3], c[4], c[5],
                              c[6], c[7], c[8], c[9], c[10], c[11]);
                if (cnt == 12 && n < 64) begin
                    vecs[n] = {c[0], c[1], c[2], c[3], c[4][0], c[5][4:0],
                               c[6], c[7][0], c[8], c[9][0], c[10][0], c[11]};
                    n++;
                end
            end
            $fclose(fd);
            n_vec = n;
            ok = (n > 0);
        end
    endtask

    task automatic drive_vector(input int idx);
        @(negedge clk);
        i_valid    = 1'b1;
        i_instr    = vecs[idx].instr;
        i_pc       = vecs[idx].pc;
        i_rs1_data = vecs[idx].rs1;
        i_rs2_data = vecs[idx].rs2;
        sent_cycle[idx] = cycle;
        exp_q.push_back(idx);
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            i_valid = 1'b0;
        end
    endtask

    task automatic check_result(input int idx);
        int      errs_before;
        vector_t v;
        errs_before = n_err;
        v = vecs[idx];
        check_bit("o_res.rd_we", o_res.rd_we, v.rd_we);
        if (v.rd_we) begin
            check_addr("o_res.rd", o_res.rd, v.rd);
            check_word("o_res.rd_data", o_res.rd_data, v.rd_data);
        end
        check_bit("o_res.br_taken", o_res.br_taken, v.br_taken);
        if (v.br_taken) check_word("o_res.target", o_res.target, v.target);
        check_bit("o_res.mem_read", o_res.mem_read, v.mem_read);
        check_bit("o_res.mem_write", o_res.mem_write, v.mem_write);
        if (v.mem_read || v.mem_write) check_word("o_res.mem_addr", o_res.mem_addr, v.mem_addr);
        if (v.mem_write) check_word("o_res.store_data", o_res.store_data, v.rs2);
        if (cycle - sent_cycle[idx] != 2) begin
            $display("test %0d came out %0d cycles after input instead of 2",
                     idx, cycle - sent_cycle[idx]);
            n_err++;
        end
        if (n_err == errs_before) begin
            n_pass++;
            $display("test %0d instr %h: pass", idx, v.instr);
        end else begin
            $display("test %0d instr %h: FAIL", idx, v.instr);
        end
    endtask

    // results and idle slots are sampled on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (!i_reset) begin
                if (o_res.valid) begin
                    if (exp_q.size() == 0) begin
                        $display("a result for rd x%0d arrived with no expected record",
                                 o_res.rd);
                        n_err++;
                    end else begin
                        check_result(exp_q.pop_front());
                        n_done++;
                    end
                end else begin
                    check_bit("o_res.rd_we on idle", o_res.rd_we, 1'b0);
                    check_bit("o_res.br_taken on idle", o_res.br_taken, 1'b0);
                    check_bit("o_res.mem_read on idle", o_res.mem_read, 1'b0);
                    check_bit("o_res.mem_write on idle", o_res.mem_write, 1'b0);
                end
            end
        end
    end

    // each vector takes at most 4 cycles of 4 ns with its idle gap
    initial begin
        wait (loaded);
        #(n_vec * 16 + 100);
        $display("watchdog expired with %0d expected results still waiting", exp_q.size());
        $display("Something failed");
        $finish;
    end

    initial begin
        bit ok;
        $timeformat(-9, 1, " ns", 10);
        void'($urandom(65));
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_instr    = '0;
        i_pc       = '0;
        i_rs1_data = '0;
        i_rs2_data = '0;
        load_vectors(ok);
        if (!ok) begin
            $display("no test vectors could be read");
            $display("Something failed");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            @(negedge clk);
            i_reset = 1'b0;
            for (int i = 0; i < n_vec; i++) begin
                // groups of four, then a short random gap
                if (i > 0 && i % 4 == 0) drive_idle($urandom_range(0, 2));
                drive_vector(i);
            end
            drive_idle(1);
            wait (n_done == n_vec);
            drive_idle(3);
            $display("%0d tests, %0d passed, %0d errors", n_vec, n_pass, n_err);
            if (n_err == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+.
source/rv32i_pkg.sv
source/control_rom.sv
source/decode_stage.sv
source/alu.sv
source/branch_cmp.sv
source/writeback_select.sv
source/exec_unit.sv
test/clock_gen.sv
test/exec_unit_tb.sv
